// ==== common/periph_xbar_config.svh ====
/* Build-time constants of the peripheral crossbar.
   Include in every file that needs master/slave counts, widths or decode options. */

`ifndef PERIPH_XBAR_CONFIG_SVH
`define PERIPH_XBAR_CONFIG_SVH

// Requester side: cores plus one extra master
`define NB_CORES            4
`define NB_MASTERS          (`NB_CORES + 1)

// Slave peripherals on the output side
`define NB_SLAVES           8

`define ADDR_WIDTH          32
`define DATA_WIDTH          32
`define BE_WIDTH            4

// Address map of the cluster peripheral window
`define CLUSTER_BASE        8'h10
`define PERIPH_REGION_LO    4'h2
`define PERIPH_REGION_HI    4'h3

// Slave index sits in the address from this bit up
`define ROUTING_LSB         16

// Unmatched addresses end up here
`define EXT_SLAVE_ID        3'd7

// Optional second base for the cluster window
`define CLUSTER_ALIAS_EN    1'b1
`define CLUSTER_ALIAS_BASE  8'h1B

`endif

// ==== common/periph_xbar_pkg.sv ====
/* Types shared by the crossbar modules and the testbench.
   Referenced with scoped names, never imported. */

`include "periph_xbar_config.svh"

package periph_xbar_pkg;

  // Slave number
  typedef logic [$clog2(`NB_SLAVES)-1:0] slave_idx_t;

  // One-hot requester id, bit i set for master i
  typedef logic [`NB_MASTERS-1:0] master_id_t;

  typedef logic [`ADDR_WIDTH-1:0] addr_t;
  typedef logic [`DATA_WIDTH-1:0] data_t;

  // Request as seen by a slave
  typedef struct packed {
    addr_t                addr;
    data_t                data;
    master_id_t           id;
    // Low for a write
    logic                 we_n;
    logic [`BE_WIDTH-1:0] be;
  } periph_req_t;

  // Response from a slave, routed back by id
  typedef struct packed {
    data_t      data;
    master_id_t id;
    logic       opc;
  } periph_resp_t;

endpackage

// ==== common/periph_req_if.sv ====
/* Decoded request of one master, from the address decoder to the arbiter bank.
   One instance per master; gnt returns the acceptance in the same cycle. */

`timescale 1ns/1ns

`include "periph_xbar_config.svh"

interface periph_req_if;

  // Request present this cycle
  logic                         valid;
  // Target slave from the address decode
  periph_xbar_pkg::slave_idx_t  sel;
  periph_xbar_pkg::periph_req_t payload;
  // Accepted by the chosen slave
  logic                         gnt;

  modport decoder (
    output valid,
    output sel,
    output payload,
    input  gnt
  );

  modport arbiter (
    input  valid,
    input  sel,
    input  payload,
    output gnt
  );

endinterface

// ==== periph_xbar/periph_addr_decode.sv ====
/* Input side of the crossbar: decodes each master's address to a slave index
   and packs the request with the master's one-hot id. Purely combinational. */

`timescale 1ns/1ns

`include "periph_xbar_config.svh"

module periph_addr_decode (
  input  logic [`NB_MASTERS-1:0]                  core_req_i,
  input  logic [`NB_MASTERS-1:0]                  core_wen_i,
  input  periph_xbar_pkg::addr_t [`NB_MASTERS-1:0] core_add_i,
  input  periph_xbar_pkg::data_t [`NB_MASTERS-1:0] core_wdata_i,
  input  logic [`NB_MASTERS-1:0][`BE_WIDTH-1:0]   core_be_i,
  periph_req_if.decoder                           req_ports [`NB_MASTERS],
  output logic [`NB_MASTERS-1:0]                  core_gnt_o
);

  localparam int unsigned IDX_W = $bits(periph_xbar_pkg::slave_idx_t);

  // Cluster window hit selects a local peripheral, anything else goes external
  function automatic periph_xbar_pkg::slave_idx_t addr_to_slave(
    input periph_xbar_pkg::addr_t addr
  );
    logic base_hit;
    logic region_hit;
    base_hit = (addr[31:24] == `CLUSTER_BASE) ||
               (`CLUSTER_ALIAS_EN && (addr[31:24] == `CLUSTER_ALIAS_BASE));
    region_hit = (addr[23:20] >= `PERIPH_REGION_LO) &&
                 (addr[23:20] <= `PERIPH_REGION_HI);
    if (base_hit && region_hit) begin
      return addr[`ROUTING_LSB +: IDX_W];
    end else begin
      return `EXT_SLAVE_ID;
    end
  endfunction

  for (genvar i = 0; i < `NB_MASTERS; i++) begin : gen_master
    periph_xbar_pkg::periph_req_t payload;

    always_comb begin
      payload.addr = core_add_i[i];
      payload.data = core_wdata_i[i];
      // Fixed one-hot id for this master
      payload.id   = periph_xbar_pkg::master_id_t'(1 << i);
      payload.we_n = core_wen_i[i];
      payload.be   = core_be_i[i];
    end

    assign req_ports[i].valid   = core_req_i[i];
    assign req_ports[i].sel     = addr_to_slave(core_add_i[i]);
    assign req_ports[i].payload = payload;

    // Grant comes back from whichever slave arbiter picked us
    assign core_gnt_o[i] = req_ports[i].gnt;
  end

endmodule

// ==== periph_xbar/periph_arbiter_bank.sv ====
/* One round-robin arbiter per slave. Picks the first requesting master after the
   last granted one, forwards its payload and grants it when the slave grants. */

`timescale 1ns/1ns

`include "periph_xbar_config.svh"

module periph_arbiter_bank (
  input  logic                                        clk_i,
  input  logic                                        rst_n_i,
  periph_req_if.arbiter                               req_ports [`NB_MASTERS],
  input  logic [`NB_SLAVES-1:0]                       sper_gnt_i,
  output logic [`NB_SLAVES-1:0]                       sper_req_o,
  output periph_xbar_pkg::periph_req_t [`NB_SLAVES-1:0] sper_req_payload_o
);

  localparam int unsigned PTR_W = $clog2(`NB_MASTERS);

  logic [`NB_MASTERS-1:0]                       mst_valid;
  periph_xbar_pkg::slave_idx_t [`NB_MASTERS-1:0] mst_sel;
  periph_xbar_pkg::periph_req_t [`NB_MASTERS-1:0] mst_payload;
  // Grant of slave s to master m
  logic [`NB_MASTERS-1:0][`NB_SLAVES-1:0]       mst_gnt;

  for (genvar m = 0; m < `NB_MASTERS; m++) begin : gen_master
    assign mst_valid[m]   = req_ports[m].valid;
    assign mst_sel[m]     = req_ports[m].sel;
    assign mst_payload[m] = req_ports[m].payload;
    // A master targets one slave, so at most one bit is set
    assign req_ports[m].gnt = |mst_gnt[m];
  end

  for (genvar s = 0; s < `NB_SLAVES; s++) begin : gen_slave
    logic [`NB_MASTERS-1:0] req_vec;
    logic [PTR_W-1:0]       last_q;
    logic [PTR_W-1:0]       win_idx;
    logic                   win_vld;

    for (genvar m = 0; m < `NB_MASTERS; m++) begin : gen_req
      assign req_vec[m] = mst_valid[m] && (mst_sel[m] == periph_xbar_pkg::slave_idx_t'(s));
      assign mst_gnt[m][s] = win_vld && (win_idx == PTR_W'(m)) && sper_gnt_i[s];
    end

    // Search starts right after the last winner and wraps around
    always_comb begin
      int unsigned cand;
      win_vld = 1'b0;
      win_idx = '0;
      for (int unsigned k = 1; k <= `NB_MASTERS; k++) begin
        cand = last_q + k;
        if (cand >= `NB_MASTERS) begin
          cand = cand - `NB_MASTERS;
        end
        if (!win_vld && req_vec[cand]) begin
          win_vld = 1'b1;
          win_idx = PTR_W'(cand);
        end
      end
    end

    assign sper_req_o[s]         = win_vld;
    assign sper_req_payload_o[s] = mst_payload[win_idx];

    // Pointer moves only on a completed transfer; last master after reset
    always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
        last_q <= PTR_W'(`NB_MASTERS - 1);
      end else if (win_vld && sper_gnt_i[s]) begin
        last_q <= win_idx;
      end
    end
  end

endmodule

// ==== periph_xbar/periph_resp_router.sv ====
/* Output side of the crossbar: returns each slave response to the master
   whose bit is set in the response id. Purely combinational, no back-pressure. */

`timescale 1ns/1ns

`include "periph_xbar_config.svh"

module periph_resp_router (
  input  logic [`NB_SLAVES-1:0]                        sper_r_valid_i,
  input  periph_xbar_pkg::periph_resp_t [`NB_SLAVES-1:0] sper_r_payload_i,
  output logic [`NB_MASTERS-1:0]                       core_r_valid_o,
  output periph_xbar_pkg::data_t [`NB_MASTERS-1:0]     core_r_rdata_o,
  output logic [`NB_MASTERS-1:0]                       core_r_opc_o
);

  for (genvar m = 0; m < `NB_MASTERS; m++) begin : gen_master
    logic [`NB_SLAVES-1:0] hit;

    // Slaves currently answering this master
    for (genvar s = 0; s < `NB_SLAVES; s++) begin : gen_hit
      assign hit[s] = sper_r_valid_i[s] && sper_r_payload_i[s].id[m];
    end

    // At most one slave answers a master in a given cycle
    always_comb begin
      core_r_valid_o[m] = 1'b0;
      core_r_rdata_o[m] = '0;
      core_r_opc_o[m]   = 1'b0;
      for (int unsigned s = 0; s < `NB_SLAVES; s++) begin
        if (hit[s]) begin
          core_r_valid_o[m] = 1'b1;
          core_r_rdata_o[m] = sper_r_payload_i[s].data;
          core_r_opc_o[m]   = sper_r_payload_i[s].opc;
        end
      end
    end
  end

endmodule

// ==== verilog/periph_xbar_top.sv ====
/* Peripheral crossbar between five masters and eight slave peripherals.
   Request, grant and response paths are combinational; only the RR pointers are registered. */

`timescale 1ns/1ns

`include "periph_xbar_config.svh"

module periph_xbar_top (
  input  logic                                        clk_i,
  input  logic                                        rst_n_i,

  // Master side
  input  logic [`NB_MASTERS-1:0]                      core_req_i,
  input  logic [`NB_MASTERS-1:0]                      core_wen_i,
  input  logic [`NB_MASTERS-1:0][`ADDR_WIDTH-1:0]     core_add_i,
  input  logic [`NB_MASTERS-1:0][`DATA_WIDTH-1:0]     core_wdata_i,
  input  logic [`NB_MASTERS-1:0][`BE_WIDTH-1:0]       core_be_i,
  output logic [`NB_MASTERS-1:0]                      core_gnt_o,
  output logic [`NB_MASTERS-1:0]                      core_r_valid_o,
  output logic [`NB_MASTERS-1:0][`DATA_WIDTH-1:0]     core_r_rdata_o,
  output logic [`NB_MASTERS-1:0]                      core_r_opc_o,

  // Slave side
  output logic [`NB_SLAVES-1:0]                       sper_req_o,
  output logic [`NB_SLAVES-1:0][`ADDR_WIDTH-1:0]      sper_add_o,
  output logic [`NB_SLAVES-1:0][`DATA_WIDTH-1:0]      sper_wdata_o,
  output logic [`NB_SLAVES-1:0]                       sper_wen_o,
  output logic [`NB_SLAVES-1:0][`BE_WIDTH-1:0]        sper_be_o,
  output logic [`NB_SLAVES-1:0][`NB_MASTERS-1:0]      sper_id_o,
  input  logic [`NB_SLAVES-1:0]                       sper_gnt_i,
  input  logic [`NB_SLAVES-1:0]                       sper_r_valid_i,
  input  logic [`NB_SLAVES-1:0][`DATA_WIDTH-1:0]      sper_r_rdata_i,
  input  logic [`NB_SLAVES-1:0][`NB_MASTERS-1:0]      sper_r_id_i,
  input  logic [`NB_SLAVES-1:0]                       sper_r_opc_i
);

  // One decoded request channel per master
  periph_req_if req_if [`NB_MASTERS] ();

  periph_xbar_pkg::periph_req_t  [`NB_SLAVES-1:0] sper_req_payload;
  periph_xbar_pkg::periph_resp_t [`NB_SLAVES-1:0] sper_resp_payload;

  periph_addr_decode i_addr_decode (
    .core_req_i   ( core_req_i   ),
    .core_wen_i   ( core_wen_i   ),
    .core_add_i   ( core_add_i   ),
    .core_wdata_i ( core_wdata_i ),
    .core_be_i    ( core_be_i    ),
    .req_ports    ( req_if       ),
    .core_gnt_o   ( core_gnt_o   )
  );

  periph_arbiter_bank i_arbiter_bank (
    .clk_i              ( clk_i            ),
    .rst_n_i            ( rst_n_i          ),
    .req_ports          ( req_if           ),
    .sper_gnt_i         ( sper_gnt_i       ),
    .sper_req_o         ( sper_req_o       ),
    .sper_req_payload_o ( sper_req_payload )
  );

  // Spread request payloads onto the slave ports, collect responses
  for (genvar s = 0; s < `NB_SLAVES; s++) begin : gen_slave_bind
    assign sper_add_o[s]   = sper_req_payload[s].addr;
    assign sper_wdata_o[s] = sper_req_payload[s].data;
    assign sper_wen_o[s]   = sper_req_payload[s].we_n;
    assign sper_be_o[s]    = sper_req_payload[s].be;
    assign sper_id_o[s]    = sper_req_payload[s].id;

    assign sper_resp_payload[s] = '{
      data: sper_r_rdata_i[s],
      id:   sper_r_id_i[s],
      opc:  sper_r_opc_i[s]
    };
  end

  periph_resp_router i_resp_router (
    .sper_r_valid_i   ( sper_r_valid_i    ),
    .sper_r_payload_i ( sper_resp_payload ),
    .core_r_valid_o   ( core_r_valid_o    ),
    .core_r_rdata_o   ( core_r_rdata_o    ),
    .core_r_opc_o     ( core_r_opc_o      )
  );

endmodule

// ==== testbench/periph_slave_model.sv ====
/* Behavioral model of the eight slave peripherals behind the crossbar.
   Grants randomly per cycle unless forced, answers one cycle after each transfer. */

`timescale 1ns/1ns

`include "periph_xbar_config.svh"

module periph_slave_model (
  input  logic                                    clk_i,
  input  logic                                    rst_n_i,
  input  logic [`NB_SLAVES-1:0]                   always_gnt_i,
  input  logic [`NB_SLAVES-1:0]                   never_gnt_i,
  input  logic [`NB_SLAVES-1:0]                   sper_req_i,
  input  logic [`NB_SLAVES-1:0][`ADDR_WIDTH-1:0]  sper_add_i,
  input  logic [`NB_SLAVES-1:0][`NB_MASTERS-1:0]  sper_id_i,
  output logic [`NB_SLAVES-1:0]                   sper_gnt_o,
  output logic [`NB_SLAVES-1:0]                   sper_r_valid_o,
  output logic [`NB_SLAVES-1:0][`DATA_WIDTH-1:0]  sper_r_rdata_o,
  output logic [`NB_SLAVES-1:0][`NB_MASTERS-1:0]  sper_r_id_o,
  output logic [`NB_SLAVES-1:0]                   sper_r_opc_o
);

  logic [`NB_SLAVES-1:0]                  xfer;
  periph_xbar_pkg::addr_t [`NB_SLAVES-1:0] xfer_addr;
  logic [`NB_SLAVES-1:0][`NB_MASTERS-1:0] xfer_id;

  initial begin
    sper_gnt_o     = '0;
    sper_r_valid_o = '0;
    sper_r_rdata_o = '0;
    sper_r_id_o    = '0;
    sper_r_opc_o   = '0;
    xfer           = '0;
  end

  // Transfers are taken mid-cycle, when the crossbar outputs have settled
  always @(negedge clk_i) begin
    xfer      = rst_n_i ? (sper_req_i & sper_gnt_o) : '0;
    xfer_addr = sper_add_i;
    xfer_id   = sper_id_i;
  end

  always @(posedge clk_i) begin
    #10;
    for (int s = 0; s < `NB_SLAVES; s++) begin
      sper_r_valid_o[s] = xfer[s];
      sper_r_rdata_o[s] = xfer[s] ? (xfer_addr[s] ^ (32'(s) * 32'h01010101)) : '0;
      sper_r_id_o[s]    = xfer[s] ? xfer_id[s] : '0;
      sper_r_opc_o[s]   = 1'b0;
      if (never_gnt_i[s]) begin
        sper_gnt_o[s] = 1'b0;
      end else if (always_gnt_i[s]) begin
        sper_gnt_o[s] = 1'b1;
      end else begin
        sper_gnt_o[s] = 1'($urandom_range(0, 1));
      end
    end
  end

endmodule

// ==== testbench/tb_periph_xbar.sv ====
/* Testbench for the peripheral crossbar with five masters and the slave model.
   Covers reset, decode, forwarding, response routing, round-robin and back-pressure. */

`timescale 1ns/1ns

`include "periph_xbar_config.svh"

module tb_periph_xbar;

  localparam int SEED         = 73883;
  localparam int GNT_TIMEOUT  = 40;
  localparam int RESP_TIMEOUT = 10;
  localparam int NM           = `NB_MASTERS;
  localparam int NS           = `NB_SLAVES;

  logic                               clk;
  logic                               rst_n_i;
  logic [NM-1:0]                      core_req_i;
  logic [NM-1:0]                      core_wen_i;
  logic [NM-1:0][`ADDR_WIDTH-1:0]     core_add_i;
  logic [NM-1:0][`DATA_WIDTH-1:0]     core_wdata_i;
  logic [NM-1:0][`BE_WIDTH-1:0]       core_be_i;
  logic [NM-1:0]                      core_gnt_o;
  logic [NM-1:0]                      core_r_valid_o;
  logic [NM-1:0][`DATA_WIDTH-1:0]     core_r_rdata_o;
  logic [NM-1:0]                      core_r_opc_o;
  logic [NS-1:0]                      sper_req_o;
  logic [NS-1:0][`ADDR_WIDTH-1:0]     sper_add_o;
  logic [NS-1:0][`DATA_WIDTH-1:0]     sper_wdata_o;
  logic [NS-1:0]                      sper_wen_o;
  logic [NS-1:0][`BE_WIDTH-1:0]       sper_be_o;
  logic [NS-1:0][NM-1:0]              sper_id_o;
  logic [NS-1:0]                      sper_gnt_i;
  logic [NS-1:0]                      sper_r_valid_i;
  logic [NS-1:0][`DATA_WIDTH-1:0]     sper_r_rdata_i;
  logic [NS-1:0][NM-1:0]              sper_r_id_i;
  logic [NS-1:0]                      sper_r_opc_i;
  logic [NS-1:0]                      always_gnt;
  logic [NS-1:0]                      never_gnt;

  // Scoreboard
  logic [NM-1:0]                      resp_pending;
  periph_xbar_pkg::data_t [NM-1:0]    exp_rdata;
  int                                 grants_seen [NM];
  int                                 resps_seen [NM];
  int                                 value_errors;
  int                                 other_errors;
  int                                 checks_done;
  int                                 ext_hits;
  int                                 cycle;
  logic                               expect_idle;
  logic                               rr_track;
  int                                 rr_order [$];
  int                                 rr_cycle [$];
  periph_xbar_pkg::addr_t             bp_addr;

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) cycle <= cycle + 1;

  periph_xbar_top DUT (
    .clk_i          ( clk            ),
    .rst_n_i        ( rst_n_i        ),
    .core_req_i     ( core_req_i     ),
    .core_wen_i     ( core_wen_i     ),
    .core_add_i     ( core_add_i     ),
    .core_wdata_i   ( core_wdata_i   ),
    .core_be_i      ( core_be_i      ),
    .core_gnt_o     ( core_gnt_o     ),
    .core_r_valid_o ( core_r_valid_o ),
    .core_r_rdata_o ( core_r_rdata_o ),
    .core_r_opc_o   ( core_r_opc_o   ),
    .sper_req_o     ( sper_req_o     ),
    .sper_add_o     ( sper_add_o     ),
    .sper_wdata_o   ( sper_wdata_o   ),
    .sper_wen_o     ( sper_wen_o     ),
    .sper_be_o      ( sper_be_o      ),
    .sper_id_o      ( sper_id_o      ),
    .sper_gnt_i     ( sper_gnt_i     ),
    .sper_r_valid_i ( sper_r_valid_i ),
    .sper_r_rdata_i ( sper_r_rdata_i ),
    .sper_r_id_i    ( sper_r_id_i    ),
    .sper_r_opc_i   ( sper_r_opc_i   )
  );

  periph_slave_model i_slave_model (
    .clk_i          ( clk            ),
    .rst_n_i        ( rst_n_i        ),
    .always_gnt_i   ( always_gnt     ),
    .never_gnt_i    ( never_gnt      ),
    .sper_req_i     ( sper_req_o     ),
    .sper_add_i     ( sper_add_o     ),
    .sper_id_i      ( sper_id_o      ),
    .sper_gnt_o     ( sper_gnt_i     ),
    .sper_r_valid_o ( sper_r_valid_i ),
    .sper_r_rdata_o ( sper_r_rdata_i ),
    .sper_r_id_o    ( sper_r_id_i    ),
    .sper_r_opc_o   ( sper_r_opc_i   )
  );

  // Cluster window with peripheral region hits a local slave and the rest goes external
  function automatic int expected_slave(input periph_xbar_pkg::addr_t addr);
    logic base_hit;
    logic region_hit;
    base_hit = (addr[31:24] == `CLUSTER_BASE) ||
               (`CLUSTER_ALIAS_EN && (addr[31:24] == `CLUSTER_ALIAS_BASE));
    region_hit = (addr[23:20] >= `PERIPH_REGION_LO) && (addr[23:20] <= `PERIPH_REGION_HI);
    if (base_hit && region_hit) begin
      return int'(addr[`ROUTING_LSB +: 3]);
    end else begin
      return int'(`EXT_SLAVE_ID);
    end
  endfunction

  function automatic periph_xbar_pkg::data_t expected_rdata(input periph_xbar_pkg::addr_t addr);
    return addr ^ (32'(expected_slave(addr)) * 32'h01010101);
  endfunction

  // Mix of cluster, alias, off-region and outside addresses
  function automatic periph_xbar_pkg::addr_t random_address();
    int         kind;
    logic [7:0] top;
    logic [3:0] region;
    kind   = $urandom_range(0, 3);
    top    = `CLUSTER_BASE;
    region = 4'($urandom_range(`PERIPH_REGION_LO, `PERIPH_REGION_HI));
    if (kind == 1) top = `CLUSTER_ALIAS_BASE;
    if (kind == 2) region = 4'($urandom_range(4, 15));
    if (kind == 3) top = 8'($urandom_range(8'h20, 8'hFF));
    return {top, region, 20'($urandom)};
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    value_errors++;
    $display("FAIL t=%0t %s: got 0x%0h, expected 0x%0h", $time, name, got, exp);
  endtask

  task automatic report_problem(input string msg);
    other_errors++;
    $display("ERROR t=%0t %s", $time, msg);
  endtask

  // One request followed by waits for its grant and its response
  task automatic issue_request(input int m, input periph_xbar_pkg::addr_t addr);
    int   waited;
    logic granted;
    @(posedge clk);
    #10;
    core_req_i[m]   = 1'b1;
    core_add_i[m]   = addr;
    core_wdata_i[m] = $urandom;
    core_be_i[m]    = 4'($urandom);
    core_wen_i[m]   = 1'($urandom);
    waited = 0;
    @(negedge clk);
    while (!core_gnt_o[m] && waited < GNT_TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    granted = core_gnt_o[m];
    assert (granted)
      else report_problem($sformatf("master %0d got no grant for address 0x%0h", m, addr));
    @(posedge clk);
    #10;
    core_req_i[m] = 1'b0;
    if (granted) begin
      waited = 0;
      @(negedge clk);
      while (!core_r_valid_o[m] && waited < RESP_TIMEOUT) begin
        @(negedge clk);
        waited++;
      end
      assert (core_r_valid_o[m])
        else report_problem($sformatf("master %0d got no response for address 0x%0h", m, addr));
    end
  endtask

  task automatic run_master(input int m, input int count, input logic to_slave3);
    periph_xbar_pkg::addr_t addr;
    for (int i = 0; i < count; i++) begin
      addr = to_slave3 ? {16'h1023, 16'($urandom)} : random_address();
      issue_request(m, addr);
    end
  endtask

  // Compares every slave transfer, grant and response against the reference
  always @(negedge clk) begin : compare_outputs
    logic [NM-1:0] xfer_seen;
    logic          found;
    int            m;
    xfer_seen = '0;
    if (expect_idle) begin
      assert (sper_req_o == '0) else report_mismatch("sper_req_o", 32'(sper_req_o), 0);
      assert (core_gnt_o == '0) else report_mismatch("core_gnt_o", 32'(core_gnt_o), 0);
      assert (core_r_valid_o == '0)
        else report_mismatch("core_r_valid_o", 32'(core_r_valid_o), 0);
    end
    for (int k = 0; k < NM; k++) begin
      if (core_r_valid_o[k]) begin
        resps_seen[k]++;
        assert (resp_pending[k])
          else report_problem($sformatf("master %0d got an unrequested response", k));
        assert (core_r_rdata_o[k] == exp_rdata[k])
          else report_mismatch($sformatf("core_r_rdata_o[%0d]", k), core_r_rdata_o[k],
                               exp_rdata[k]);
        assert (!core_r_opc_o[k]) else report_mismatch($sformatf("core_r_opc_o[%0d]", k), 1, 0);
        resp_pending[k] = 1'b0;
      end
    end
    for (int s = 0; s < NS; s++) begin
      if (sper_req_o[s]) begin
        found = 1'b0;
        for (int k = 0; k < NM; k++) begin
          if (core_req_i[k] && expected_slave(core_add_i[k]) == s) found = 1'b1;
        end
        assert (found)
          else report_problem($sformatf("slave %0d requested with no master aiming at it", s));
      end
      if (sper_req_o[s] && sper_gnt_i[s]) begin
        m = -1;
        for (int k = 0; k < NM; k++) begin
          if (sper_id_o[s] == periph_xbar_pkg::master_id_t'(1 << k)) m = k;
        end
        assert (m >= 0) else report_problem($sformatf("slave %0d got an id that is not one-hot", s));
        if (m >= 0) begin
          checks_done++;
          assert (core_req_i[m]) else report_problem($sformatf("transfer for idle master %0d", m));
          assert (expected_slave(core_add_i[m]) == s)
            else report_mismatch($sformatf("slave of master %0d", m), s, expected_slave(core_add_i[m]));
          assert (sper_add_o[s] == core_add_i[m])
            else report_mismatch($sformatf("sper_add_o[%0d]", s), sper_add_o[s], core_add_i[m]);
          assert (sper_wdata_o[s] == core_wdata_i[m])
            else report_mismatch($sformatf("sper_wdata_o[%0d]", s), sper_wdata_o[s], core_wdata_i[m]);
          assert (sper_be_o[s] == core_be_i[m])
            else report_mismatch($sformatf("sper_be_o[%0d]", s), 32'(sper_be_o[s]), 32'(core_be_i[m]));
          assert (sper_wen_o[s] == core_wen_i[m])
            else report_mismatch($sformatf("sper_wen_o[%0d]", s), 32'(sper_wen_o[s]), 32'(core_wen_i[m]));
          xfer_seen[m]    = 1'b1;
          grants_seen[m]++;
          exp_rdata[m]    = expected_rdata(core_add_i[m]);
          resp_pending[m] = 1'b1;
          if (s == int'(`EXT_SLAVE_ID)) ext_hits++;
          if (rr_track && s == 3) begin
            rr_order.push_back(m);
            rr_cycle.push_back(cycle);
          end
        end
      end
    end
    for (int k = 0; k < NM; k++) begin
      assert (core_gnt_o[k] == xfer_seen[k])
        else report_mismatch($sformatf("core_gnt_o[%0d]", k), 32'(core_gnt_o[k]), 32'(xfer_seen[k]));
    end
  end

  initial begin
    void'($urandom(SEED));
    rst_n_i      = 1'b0;
    core_req_i   = '0;
    core_wen_i   = '1;
    core_add_i   = '0;
    core_wdata_i = '0;
    core_be_i    = '0;
    always_gnt   = '0;
    never_gnt    = '0;
    resp_pending = '0;
    exp_rdata    = '0;
    value_errors = 0;
    other_errors = 0;
    checks_done  = 0;
    ext_hits     = 0;
    cycle        = 0;
    rr_track     = 1'b0;
    expect_idle  = 1'b1;
    repeat (2) @(posedge clk);
    #10;
    rst_n_i = 1'b1;
    repeat (3) @(posedge clk);
    #10;
    expect_idle = 1'b0;

    // All masters hammer slave 3 while it always grants
    always_gnt[3] = 1'b1;
    rr_track      = 1'b1;
    fork
      run_master(0, 3, 1'b1);
      run_master(1, 3, 1'b1);
      run_master(2, 3, 1'b1);
      run_master(3, 3, 1'b1);
      run_master(4, 3, 1'b1);
    join
    rr_track      = 1'b0;
    always_gnt[3] = 1'b0;
    assert (rr_order.size() == 3 * NM)
      else report_problem("round-robin run saw a wrong transfer count");
    for (int i = 0; i < rr_order.size(); i++) begin
      assert (rr_order[i] == i % NM)
        else report_mismatch("round-robin master", 32'(rr_order[i]), i % NM);
      assert (rr_cycle[i] == rr_cycle[0] + i)
        else report_problem("round-robin transfers not back to back");
    end

    // Random traffic from all masters at once
    fork
      run_master(0, 12, 1'b0);
      run_master(1, 12, 1'b0);
      run_master(2, 12, 1'b0);
      run_master(3, 12, 1'b0);
      run_master(4, 12, 1'b0);
    join

    // Slave 5 withholds its grant while master 2 waits
    bp_addr = {16'h1035, 16'($urandom)};
    @(negedge clk);
    never_gnt[5] = 1'b1;
    fork
      issue_request(2, bp_addr);
      begin
        @(posedge clk);
        repeat (6) begin
          @(negedge clk);
          assert (sper_req_o[5]) else report_mismatch("sper_req_o[5]", 0, 1);
          assert (sper_add_o[5] == bp_addr) else report_mismatch("sper_add_o[5]", sper_add_o[5], bp_addr);
          assert (sper_wdata_o[5] == core_wdata_i[2])
            else report_mismatch("sper_wdata_o[5]", sper_wdata_o[5], core_wdata_i[2]);
          assert (sper_be_o[5] == core_be_i[2])
            else report_mismatch("sper_be_o[5]", 32'(sper_be_o[5]), 32'(core_be_i[2]));
          assert (sper_wen_o[5] == core_wen_i[2])
            else report_mismatch("sper_wen_o[5]", 32'(sper_wen_o[5]), 32'(core_wen_i[2]));
          assert (sper_id_o[5] == periph_xbar_pkg::master_id_t'(1 << 2))
            else report_mismatch("sper_id_o[5]", 32'(sper_id_o[5]), 32'h4);
          assert (!core_gnt_o[2]) else report_mismatch("core_gnt_o[2]", 1, 0);
          assert (!core_r_valid_o[2]) else report_mismatch("core_r_valid_o[2]", 1, 0);
        end
        @(negedge clk);
        never_gnt[5]  = 1'b0;
        always_gnt[5] = 1'b1;
      end
    join
    always_gnt[5] = 1'b0;

    repeat (3) @(posedge clk);
    for (int k = 0; k < NM; k++) begin
      assert (grants_seen[k] == resps_seen[k])
        else report_problem($sformatf("master %0d had %0d grants but %0d responses", k,
                                      grants_seen[k], resps_seen[k]));
    end
    assert (ext_hits > 0) else report_problem("no transfer reached the external slave");

    $display("Transfers checked: %0d, value errors: %0d, other errors: %0d",
             checks_done, value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// ==== files.f ====
+incdir+common
common/periph_xbar_pkg.sv
common/periph_req_if.sv
periph_xbar/periph_addr_decode.sv
periph_xbar/periph_arbiter_bank.sv
periph_xbar/periph_resp_router.sv
verilog/periph_xbar_top.sv
testbench/periph_slave_model.sv
testbench/tb_periph_xbar.sv

// ==== Makefile ====
# Verilator build and regression run for the peripheral crossbar
# Override any variable on the command line, e.g. make run LOG=my.log

VERILATOR ?= verilator
TOP       ?= tb_periph_xbar
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(filter-out +incdir+%,$(shell cat $(FILELIST)))
HDRS := $(wildcard common/*.svh)
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

# Rebuilt only when a source, header or the file list changes
$(SIM): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(SIM)
	@./$(SIM) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Regression failed" $(LOG); then \
	  echo "Simulation reported a failure, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
